// ==== hdl/bp_pkg.sv ====
package bp_pkg;

    // core address width, fixed by the fetch unit
    localparam int PC_W = 32;

    // instruction address
    typedef logic [PC_W-1:0] pc_t;

    // 2-bit saturating direction counter
    typedef logic [1:0] ctr_t;

    // counter encoding
    // upper bit set means predict taken
    localparam ctr_t CTR_STRONG_NT = 2'd0;
    localparam ctr_t CTR_WEAK_NT   = 2'd1;
    localparam ctr_t CTR_WEAK_T    = 2'd2;
    localparam ctr_t CTR_STRONG_T  = 2'd3;

    // direction read out of a counter
    function automatic logic ctr_is_taken(input ctr_t ctr);
        return ctr[1];
    endfunction

    // one saturating step toward the resolved outcome
    function automatic ctr_t ctr_next(input ctr_t ctr, input logic taken);
        ctr_t next_ctr;
        if (taken) begin
            // hold at the top
            if (ctr == CTR_STRONG_T) begin
                next_ctr = CTR_STRONG_T;
            end else begin
                next_ctr = ctr + 2'd1;
            end
        end else begin
            // hold at the bottom
            if (ctr == CTR_STRONG_NT) begin
                next_ctr = CTR_STRONG_NT;
            end else begin
                next_ctr = ctr - 2'd1;
            end
        end
        return next_ctr;
    endfunction

endpackage

// ==== hdl/branch_target_buffer.sv ====
`timescale 1ns/100ps

module branch_target_buffer #(
    parameter int BTB_IDX_W = 4
) (
    input  logic        clk,
    input  logic        arst_n_i,
    // fetch side lookup
    input  bp_pkg::pc_t lookup_pc_i,
    input  logic        lookup_valid_i,
    // resolved branch from execute
    input  bp_pkg::pc_t upd_pc_i,
    input  logic        upd_valid_i,
    input  logic        upd_taken_i,
    input  bp_pkg::pc_t upd_target_i,
    // registered lookup result
    output logic        hit_o,
    output bp_pkg::pc_t target_o
);

    import bp_pkg::*;

    // number of entries
    localparam int ENTRIES = 1 << BTB_IDX_W;
    // first pc bit above the index
    localparam int TAG_LSB = BTB_IDX_W + 2;
    // everything above the index is tag
    localparam int TAG_W = PC_W - TAG_LSB;

    typedef logic [BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [TAG_W-1:0]     btb_tag_t;

    // per entry valid flags
    logic [ENTRIES-1:0] valid_q;

    // tag and target storage
    btb_tag_t tag_mem    [ENTRIES];
    pc_t      target_mem [ENTRIES];

    // lookup side fields
    btb_idx_t lk_idx;
    btb_tag_t lk_tag;
    logic     lk_match;

    // update side fields
    btb_idx_t up_idx;
    btb_tag_t up_tag;
    logic     up_write;

    // registered result
    logic hit_q;
    pc_t  target_q;

    // word pc bits pick the entry
    // two alignment bits are dropped
    assign lk_idx = lookup_pc_i[TAG_LSB-1:2];
    assign lk_tag = lookup_pc_i[PC_W-1:TAG_LSB];

    assign up_idx = upd_pc_i[TAG_LSB-1:2];
    assign up_tag = upd_pc_i[PC_W-1:TAG_LSB];

    // only taken branches are worth a target
    // a not-taken report leaves the entry as it was
    assign up_write = upd_valid_i && upd_taken_i;

    // hit needs a valid entry and a matching tag
    // valid low masks the unwritten tag
    assign lk_match = valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag);

    // valid flags
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (up_write) begin
            valid_q[up_idx] <= 1'b1;
        end
    end

    // tag and target written together with the valid flag
    always_ff @(posedge clk) begin
        if (up_write) begin
            tag_mem[up_idx]    <= up_tag;
            target_mem[up_idx] <= upd_target_i;
        end
    end

    // lookup hit
    // sees the table from before this edge
    // drops on any cycle without a lookup
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= lookup_valid_i && lk_match;
        end
    end

    // lookup target
    // only meaningful while hit_q is set
    always_ff @(posedge clk) begin
        if (lookup_valid_i) begin
            target_q <= target_mem[lk_idx];
        end
    end

    assign hit_o    = hit_q;
    assign target_o = target_q;

    // execute only reports word aligned targets
    a_upd_target_aligned : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        up_write |-> (upd_target_i[1:0] == 2'b00)
    ) else begin
        $error("btb: unaligned target written for pc %h", upd_pc_i);
    end

    // a hit is always the answer to a lookup one edge earlier
    a_hit_after_lookup : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        $rose(hit_o) |-> $past(lookup_valid_i)
    ) else begin
        $error("btb: hit raised without a lookup on the previous edge");
    end

endmodule

// ==== hdl/gshare_direction.sv ====
`timescale 1ns/100ps

module gshare_direction #(
    parameter int PHT_IDX_W = 6
) (
    input  logic        clk,
    input  logic        arst_n_i,
    // fetch side lookup
    input  bp_pkg::pc_t lookup_pc_i,
    input  logic        lookup_valid_i,
    // resolved branch from execute
    input  bp_pkg::pc_t upd_pc_i,
    input  logic        upd_valid_i,
    input  logic        upd_taken_i,
    // registered direction
    output logic        taken_o
);

    import bp_pkg::*;

    // pattern table size
    // history length equals the index width
    localparam int PHT_ENTRIES = 1 << PHT_IDX_W;

    typedef logic [PHT_IDX_W-1:0] pht_idx_t;

    // global history of resolved outcomes
    // newest outcome in bit 0
    pht_idx_t hist_q;

    // pattern table of saturating counters
    ctr_t pht_q [PHT_ENTRIES];

    // hashed indices
    pht_idx_t lk_idx;
    pht_idx_t up_idx;

    // counter under update before its step
    ctr_t up_ctr;

    // registered direction bit
    logic taken_q;

    // gshare hash
    // word pc bits xor history, both sides use the same history
    assign lk_idx = lookup_pc_i[PHT_IDX_W+1:2] ^ hist_q;
    assign up_idx = upd_pc_i[PHT_IDX_W+1:2] ^ hist_q;

    assign up_ctr = pht_q[up_idx];

    // pattern table
    // all counters start weakly not taken
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= CTR_WEAK_NT;
            end
        end else if (upd_valid_i) begin
            pht_q[up_idx] <= ctr_next(up_ctr, upd_taken_i);
        end
    end

    // history shifts on resolved updates only
    // no speculative shift on predictions
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hist_q <= '0;
        end else if (upd_valid_i) begin
            hist_q <= {hist_q[PHT_IDX_W-2:0], upd_taken_i};
        end
    end

    // lookup direction
    // reads counters and history from before the edge
    // low whenever no lookup was presented
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            taken_q <= 1'b0;
        end else begin
            taken_q <= lookup_valid_i && ctr_is_taken(pht_q[lk_idx]);
        end
    end

    assign taken_o = taken_q;

    // updated entry moves toward the outcome and never wraps
    a_ctr_saturates : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        upd_valid_i |=>
            ($past(upd_taken_i) ? (pht_q[$past(up_idx)] >= $past(up_ctr))
                                : (pht_q[$past(up_idx)] <= $past(up_ctr)))
    ) else begin
        $error("gshare: counter wrapped past its range");
    end

endmodule

// ==== hdl/branch_predictor.sv ====
`timescale 1ns/100ps

module branch_predictor #(
    parameter int BTB_IDX_W = 4,
    parameter int PHT_IDX_W = 6
) (
    input  logic        clk,
    input  logic        arst_n_i,
    // fetch request
    input  bp_pkg::pc_t pc_i,
    input  logic        pc_valid_i,
    // resolved branch from execute
    input  bp_pkg::pc_t ex_pc_i,
    input  logic        ex_update_i,
    input  logic        ex_taken_i,
    input  bp_pkg::pc_t ex_target_i,
    // prediction one cycle after the request
    output logic        taken_o,
    output bp_pkg::pc_t target_o,
    output logic        pred_valid_o
);

    import bp_pkg::*;

    // sequential fetch step without compressed instructions
    localparam pc_t INSN_BYTES = pc_t'(4);

    // table results are already registered
    logic btb_hit;
    pc_t  btb_target;
    logic dir_taken;

    // registered request
    logic pred_valid_q;
    // registered pc plus 4
    pc_t  fall_pc_q;

    // request valid flag
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pred_valid_q <= 1'b0;
        end else begin
            pred_valid_q <= pc_valid_i;
        end
    end

    // fall-through address of the request
    // zero out of reset so target_o starts at zero
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fall_pc_q <= '0;
        end else if (pc_valid_i) begin
            fall_pc_q <= pc_i + INSN_BYTES;
        end
    end

    // target store
    branch_target_buffer #(
        .BTB_IDX_W (BTB_IDX_W)
    ) u_btb (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .lookup_pc_i    (pc_i),
        .lookup_valid_i (pc_valid_i),
        .upd_pc_i       (ex_pc_i),
        .upd_valid_i    (ex_update_i),
        .upd_taken_i    (ex_taken_i),
        .upd_target_i   (ex_target_i),
        .hit_o          (btb_hit),
        .target_o       (btb_target)
    );

    // direction
    gshare_direction #(
        .PHT_IDX_W (PHT_IDX_W)
    ) u_gshare (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .lookup_pc_i    (pc_i),
        .lookup_valid_i (pc_valid_i),
        .upd_pc_i       (ex_pc_i),
        .upd_valid_i    (ex_update_i),
        .upd_taken_i    (ex_taken_i),
        .taken_o        (dir_taken)
    );

    // taken needs both a known target and a taken counter
    assign taken_o = btb_hit && dir_taken;

    // redirect or fall through
    assign target_o = taken_o ? btb_target : fall_pc_q;

    assign pred_valid_o = pred_valid_q;

endmodule

// ==== verif/bp_checker.sv ====
`timescale 1ns/100ps

module bp_checker #(
    parameter int BTB_IDX_W = 4,
    parameter int PHT_IDX_W = 6
) (
    input  logic        clk,
    input  logic        arst_n_i,
    // fetch and execute inputs of the DUT
    input  bp_pkg::pc_t pc_i,
    input  logic        pc_valid_i,
    input  bp_pkg::pc_t ex_pc_i,
    input  logic        ex_update_i,
    input  logic        ex_taken_i,
    input  bp_pkg::pc_t ex_target_i,
    // DUT prediction
    input  logic        dut_taken_i,
    input  bp_pkg::pc_t dut_target_i,
    input  logic        dut_valid_i,
    // hand worked expectation of a table row
    input  logic        exp_check_i,
    input  logic        exp_taken_i,
    input  bp_pkg::pc_t exp_target_i,
    output int          model_errs_o,
    output int          table_errs_o
);

    import bp_pkg::*;

    localparam int BTB_N = 1 << BTB_IDX_W;
    localparam int PHT_N = 1 << PHT_IDX_W;
    // pc bits above this shift form the btb tag
    localparam int TAG_SHIFT = BTB_IDX_W + 2;

    // reference state
    logic [PHT_IDX_W-1:0] hist;
    ctr_t pht [PHT_N];
    logic btb_vld [BTB_N];
    pc_t  btb_pc  [BTB_N];
    pc_t  btb_tgt [BTB_N];

    // prediction due at the next falling edge
    logic want_valid;
    logic want_taken;
    pc_t  want_target;
    pc_t  want_pc;
    logic tab_check;
    logic tab_taken;
    pc_t  tab_target;

    int model_errs = 0;
    int table_errs = 0;

    // counter moves one step toward the outcome, held at 0 and 3
    function automatic ctr_t saturate_step(input ctr_t c, input logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    always @(posedge clk or negedge arst_n_i) begin : ref_model
        int bi;
        int pi;
        if (!arst_n_i) begin
            hist = '0;
            for (int i = 0; i < PHT_N; i++) begin
                pht[i] = CTR_WEAK_NT;
            end
            for (int i = 0; i < BTB_N; i++) begin
                btb_vld[i] = 1'b0;
            end
            want_valid = 1'b0;
            tab_check  = 1'b0;
        end else begin
            want_valid = pc_valid_i;
            tab_check  = pc_valid_i && exp_check_i;
            // lookup first, it sees the state from before this edge
            if (pc_valid_i) begin
                bi = (pc_i >> 2) % BTB_N;
                pi = ((pc_i >> 2) % PHT_N) ^ hist;
                want_pc     = pc_i;
                want_taken  = btb_vld[bi] && ((btb_pc[bi] >> TAG_SHIFT) == (pc_i >> TAG_SHIFT))
                              && pht[pi][1];
                want_target = want_taken ? btb_tgt[bi] : pc_i + 32'd4;
                tab_taken   = exp_taken_i;
                tab_target  = exp_target_i;
            end
            // then train
            if (ex_update_i) begin
                pi = ((ex_pc_i >> 2) % PHT_N) ^ hist;
                pht[pi] = saturate_step(pht[pi], ex_taken_i);
                hist = {hist[PHT_IDX_W-2:0], ex_taken_i};
                if (ex_taken_i) begin
                    bi = (ex_pc_i >> 2) % BTB_N;
                    btb_vld[bi] = 1'b1;
                    btb_pc[bi]  = ex_pc_i;
                    btb_tgt[bi] = ex_target_i;
                end
            end
        end
    end

    // outputs settled since the rising edge
    always @(negedge clk) begin
        if (arst_n_i) begin
            if (dut_valid_i !== want_valid) begin
                model_errs++;
                $display("[FAIL] %0t: pred_valid_o is %b, model expects %b",
                         $time, dut_valid_i, want_valid);
            end else if (want_valid) begin
                if (dut_taken_i !== want_taken || dut_target_i !== want_target) begin
                    model_errs++;
                    $display("[FAIL] %0t: pc %h predicted %b/%h, model expects %b/%h",
                             $time, want_pc, dut_taken_i, dut_target_i, want_taken,
                             want_target);
                end
                if (tab_check && (dut_taken_i !== tab_taken || dut_target_i !== tab_target)) begin
                    table_errs++;
                    $display("[FAIL] %0t: pc %h predicted %b/%h, table expects %b/%h",
                             $time, want_pc, dut_taken_i, dut_target_i, tab_taken,
                             tab_target);
                end
            end
        end
    end

    assign model_errs_o = model_errs;
    assign table_errs_o = table_errs;

endmodule

// ==== verif/tb_branch_predictor.sv ====
`timescale 1ns/100ps

module tb_branch_predictor;

    import bp_pkg::*;

    localparam int BTB_IDX_W  = 4;
    localparam int PHT_IDX_W  = 6;
    localparam int CLK_PERIOD = 40;
    // cycles allowed for a prediction to come back
    localparam int WAIT_LIMIT = 8;
    localparam int RAND_STEPS = 400;

    // one stimulus row, expected columns worked out by hand
    typedef struct packed {
        logic lk;
        logic up;
        pc_t  pc;
        logic taken;
        pc_t  target;
        logic exp_taken;
        pc_t  exp_target;
    } row_t;

    logic clk;
    logic arst_n_i;
    pc_t  pc_i;
    logic pc_valid_i;
    pc_t  ex_pc_i;
    logic ex_update_i;
    logic ex_taken_i;
    pc_t  ex_target_i;
    logic taken_o;
    pc_t  target_o;
    logic pred_valid_o;

    logic exp_check;
    logic exp_taken;
    pc_t  exp_target;
    int   model_errs;
    int   table_errs;
    int   timeouts = 0;

    integer      seed;
    logic [31:0] rnd;
    row_t        rows [$];

    branch_predictor #(
        .BTB_IDX_W (BTB_IDX_W),
        .PHT_IDX_W (PHT_IDX_W)
    ) dut_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .pc_i         (pc_i),
        .pc_valid_i   (pc_valid_i),
        .ex_pc_i      (ex_pc_i),
        .ex_update_i  (ex_update_i),
        .ex_taken_i   (ex_taken_i),
        .ex_target_i  (ex_target_i),
        .taken_o      (taken_o),
        .target_o     (target_o),
        .pred_valid_o (pred_valid_o)
    );

    bp_checker #(
        .BTB_IDX_W (BTB_IDX_W),
        .PHT_IDX_W (PHT_IDX_W)
    ) u_checker (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .pc_i         (pc_i),
        .pc_valid_i   (pc_valid_i),
        .ex_pc_i      (ex_pc_i),
        .ex_update_i  (ex_update_i),
        .ex_taken_i   (ex_taken_i),
        .ex_target_i  (ex_target_i),
        .dut_taken_i  (taken_o),
        .dut_target_i (target_o),
        .dut_valid_i  (pred_valid_o),
        .exp_check_i  (exp_check),
        .exp_taken_i  (exp_taken),
        .exp_target_i (exp_target),
        .model_errs_o (model_errs),
        .table_errs_o (table_errs)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic add_row(input logic lk, input logic up, input pc_t pc, input logic taken,
                           input pc_t target, input logic e_taken, input pc_t e_target);
        rows.push_back('{lk, up, pc, taken, target, e_taken, e_target});
    endtask

    // n taken updates of one branch, pushes ones into the history
    task automatic add_taken_run(input pc_t pc, input pc_t target, input int n);
        for (int i = 0; i < n; i++) begin
            add_row(1'b0, 1'b1, pc, 1'b1, target, 1'b0, '0);
        end
    endtask

    // result is normally up at the first falling edge
    task automatic await_prediction();
        int waited;
        waited = 0;
        while (!pred_valid_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!pred_valid_o) begin
            timeouts++;
            $display("timeout: no prediction came back within %0d cycles, time %0t",
                     WAIT_LIMIT, $time);
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic apply_row(input row_t r);
        pc_valid_i  = r.lk;
        pc_i        = r.pc;
        ex_update_i = r.up;
        ex_pc_i     = r.pc;
        ex_taken_i  = r.taken;
        ex_target_i = r.target;
        exp_check   = r.lk;
        exp_taken   = r.exp_taken;
        exp_target  = r.exp_target;
        @(negedge clk);
        if (r.lk) begin
            await_prediction();
        end
    endtask

    task automatic build_table();
        // cold tables, fall through
        add_row(1'b1, 1'b0, 32'h0000_0100, 1'b0, '0, 1'b0, 32'h0000_0104);
        add_row(1'b1, 1'b0, 32'h0000_2000, 1'b0, '0, 1'b0, 32'h0000_2004);
        // history to all ones
        add_taken_run(32'h0000_0300, 32'h0000_0500, 6);
        // btb hit but counter 63 still weak not taken
        add_row(1'b1, 1'b0, 32'h0000_0300, 1'b0, '0, 1'b0, 32'h0000_0304);
        // train 0x1040 at counter 47 up to strong taken
        add_row(1'b0, 1'b1, 32'h0000_1040, 1'b1, 32'h0000_2000, 1'b0, '0);
        add_row(1'b0, 1'b1, 32'h0000_1040, 1'b1, 32'h0000_2000, 1'b0, '0);
        add_row(1'b1, 1'b0, 32'h0000_1040, 1'b0, '0, 1'b1, 32'h0000_2000);
        // same btb slot, other tag, counter 31 weak taken
        add_row(1'b1, 1'b0, 32'h0000_1080, 1'b0, '0, 1'b0, 32'h0000_1084);
        // first not taken, history restored by a filler branch
        add_row(1'b0, 1'b1, 32'h0000_1040, 1'b0, '0, 1'b0, '0);
        add_taken_run(32'h0000_0304, 32'h0000_0600, 6);
        add_row(1'b1, 1'b0, 32'h0000_1040, 1'b0, '0, 1'b1, 32'h0000_2000);
        // second not taken flips it
        add_row(1'b0, 1'b1, 32'h0000_1040, 1'b0, '0, 1'b0, '0);
        add_taken_run(32'h0000_0304, 32'h0000_0600, 6);
        add_row(1'b1, 1'b0, 32'h0000_1040, 1'b0, '0, 1'b0, 32'h0000_1044);
        // same edge update is not seen by the lookup
        add_row(1'b1, 1'b1, 32'h0000_1040, 1'b1, 32'h0000_2000, 1'b0, 32'h0000_1044);
        add_row(1'b1, 1'b0, 32'h0000_1040, 1'b0, '0, 1'b1, 32'h0000_2000);
        // alternating branch, ends on history 42
        for (int i = 0; i < 6; i++) begin
            add_row(1'b0, 1'b1, 32'h0000_0400, 1'b1, 32'h0000_0800, 1'b0, '0);
            add_row(1'b0, 1'b1, 32'h0000_0400, 1'b0, '0, 1'b0, '0);
        end
        add_row(1'b1, 1'b0, 32'h0000_0400, 1'b0, '0, 1'b1, 32'h0000_0800);
        // one more taken moves to history 21, counter there is strong not taken
        add_row(1'b0, 1'b1, 32'h0000_0400, 1'b1, 32'h0000_0800, 1'b0, '0);
        add_row(1'b1, 1'b0, 32'h0000_0400, 1'b0, '0, 1'b0, 32'h0000_0404);
    endtask

    initial begin
        seed        = 32'hc10c40a2;
        arst_n_i    = 1'b0;
        pc_i        = '0;
        pc_valid_i  = 1'b0;
        ex_pc_i     = '0;
        ex_update_i = 1'b0;
        ex_taken_i  = 1'b0;
        ex_target_i = '0;
        exp_check   = 1'b0;
        exp_taken   = 1'b0;
        exp_target  = '0;
        repeat (2) @(negedge clk);
        arst_n_i = 1'b1;
        build_table();
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        // lookup every cycle, random updates over a small aliasing pc range
        exp_check = 1'b0;
        repeat (RAND_STEPS) begin
            rnd         = $random(seed);
            pc_valid_i  = 1'b1;
            pc_i        = {22'd0, rnd[7:0], 2'b00};
            ex_update_i = rnd[8];
            ex_pc_i     = {22'd0, rnd[16:9], 2'b00};
            ex_taken_i  = rnd[17];
            ex_target_i = $random(seed);
            ex_target_i[1:0] = 2'b00;
            @(negedge clk);
            await_prediction();
        end
        pc_valid_i  = 1'b0;
        ex_update_i = 1'b0;
        repeat (2) @(negedge clk);
        $display("closing counts: model mismatches %0d, table mismatches %0d, timeouts %0d",
                 model_errs, table_errs, timeouts);
        if (model_errs == 0 && table_errs == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hdl/bp_pkg.sv
hdl/branch_target_buffer.sv
hdl/gshare_direction.sv
hdl/branch_predictor.sv
verif/bp_checker.sv
verif/tb_branch_predictor.sv
